/* source/uart_pkg.sv */
// Shared types and constants for the UART register port, imported by every RTL module
`default_nettype none

package uart_pkg;

    // One byte as it travels on the serial line
    typedef logic [7:0] byte_t;

    // Index into the register file
    typedef logic [3:0] reg_addr_t;

    // Clocks per serial bit, wide enough for slow rates on fast clocks
    typedef logic [13:0] baud_div_t;

    // Kind of command that leaves the decoder and the executor
    typedef enum logic [1:0] {
        CMD_READ,
        CMD_WRITE,
        CMD_ERROR
    } cmd_op_t;

    // Opcode bytes that start a command frame
    localparam byte_t OP_WRITE = 8'h57;
    localparam byte_t OP_READ  = 8'h52;

    // Answer sent after a successful write
    localparam byte_t RESP_OK = 8'h4B;

    // Answer sent for an unknown opcode or an address out of range
    localparam byte_t RESP_ERR = 8'h3F;

    // Number of registers behind the port
    // Addresses at or above this value are rejected by the decoder
    localparam int REG_COUNT = 16;

endpackage

`default_nettype wire

/* source/uart_rx.sv */
// Serial 8N1 receiver that filters the line and hands each byte on with a one-cycle pulse
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
    parameter int unsigned clk_hz = 1_000_000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    input  logic [31:0]     uart_speed,
    output logic            rx_valid,
    output uart_pkg::byte_t rx_byte
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t  state;
    baud_div_t  baud_div;
    baud_div_t  tick_count;
    logic [3:0] rx_hist;
    logic       rx_filt;
    logic       rx_filt_d;
    logic       bit_en;
    logic       bit_tick;
    logic [2:0] bits_left;
    byte_t      shift;

    // Clocks per bit at the requested line speed
    assign baud_div = baud_div_t'(clk_hz / uart_speed);

    // The filtered line only follows rx after four equal samples in a row
    // This also brings the asynchronous input into the clock domain
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_hist <= '1;
            rx_filt <= 1'b1;
        end else begin
            rx_hist <= {rx_hist[2:0], rx};
            if (rx_hist == 4'b0000) begin
                rx_filt <= 1'b0;
            end else if (rx_hist == 4'b1111) begin
                rx_filt <= 1'b1;
            end
        end
    end

    // Bit timer, loaded with half a period while idle
    // The first tick then lands in the middle of the start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_count <= baud_div_t'(1);
            bit_tick   <= 1'b0;
        end else if (bit_en) begin
            if (tick_count == baud_div) begin
                tick_count <= baud_div_t'(1);
                bit_tick   <= 1'b1;
            end else begin
                tick_count <= tick_count + baud_div_t'(1);
                bit_tick   <= 1'b0;
            end
        end else begin
            tick_count <= {1'b0, baud_div[13:1]};
            bit_tick   <= 1'b0;
        end
    end

    // A falling edge while idle starts the timer
    // Once the FSM is idle again and the line is high, the timer stops
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_en    <= 1'b0;
            rx_filt_d <= 1'b1;
        end else begin
            rx_filt_d <= rx_filt;
            if (state == IDLE && rx_filt_d) begin
                bit_en <= ~rx_filt;
            end
        end
    end

    // Frame FSM, advanced once per bit tick
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (bit_tick) begin
                case (state)
                    IDLE: begin
                        // A start bit still low at mid-bit is genuine
                        if (!rx_filt) begin
                            bits_left <= 3'd7;
                            state     <= DATA;
                        end
                    end
                    DATA: begin
                        // LSB arrives first, so shift in from the top
                        shift <= {rx_filt, shift[7:1]};
                        if (bits_left == 3'd0) begin
                            state <= STOP;
                        end else begin
                            bits_left <= bits_left - 3'd1;
                        end
                    end
                    STOP: begin
                        // A low stop bit is a framing error and the byte is dropped
                        state    <= IDLE;
                        rx_valid <= rx_filt;
                        rx_byte  <= shift;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/cmd_decode.sv */
// Frame parser that collects received bytes into one read, write or error command
`timescale 1ns/1ns
`default_nettype none

module cmd_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx_valid,
    input  uart_pkg::byte_t     rx_byte,
    input  logic                cmd_ready,
    output logic                cmd_valid,
    output uart_pkg::cmd_op_t   cmd_op,
    output uart_pkg::reg_addr_t cmd_addr,
    output uart_pkg::byte_t     cmd_data
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        OPCODE,
        ADDR,
        DATA,
        HOLD
    } dec_state_t;

    dec_state_t state;

    // A finished command is offered for as long as the parser sits in HOLD
    assign cmd_valid = (state == HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= OPCODE;
        end else begin
            case (state)
                OPCODE: begin
                    if (rx_valid) begin
                        if (rx_byte == OP_WRITE || rx_byte == OP_READ) begin
                            state <= ADDR;
                        end else begin
                            // An unknown opcode is a frame of one byte
                            state <= HOLD;
                        end
                    end
                end
                ADDR: begin
                    if (rx_valid) begin
                        // A write always takes its data byte, even with a bad address
                        if (cmd_op == CMD_WRITE) begin
                            state <= DATA;
                        end else begin
                            state <= HOLD;
                        end
                    end
                end
                DATA: begin
                    if (rx_valid) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    // Bytes arriving here are dropped on purpose
                    if (cmd_ready) begin
                        state <= OPCODE;
                    end
                end
                default: begin
                    state <= OPCODE;
                end
            endcase
        end
    end

    // Command fields, captured as their bytes arrive
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                OPCODE: begin
                    if (rx_byte == OP_WRITE) begin
                        cmd_op <= CMD_WRITE;
                    end else if (rx_byte == OP_READ) begin
                        cmd_op <= CMD_READ;
                    end else begin
                        cmd_op <= CMD_ERROR;
                    end
                end
                ADDR: begin
                    cmd_addr <= rx_byte[3:0];
                    if (rx_byte >= byte_t'(REG_COUNT)) begin
                        cmd_op <= CMD_ERROR;
                    end
                end
                DATA: begin
                    cmd_data <= rx_byte;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/reg_execute.sv */
// Register file of sixteen bytes that carries out commands and reports each outcome
`timescale 1ns/1ns
`default_nettype none

module reg_execute (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  uart_pkg::cmd_op_t   cmd_op,
    input  uart_pkg::reg_addr_t cmd_addr,
    input  uart_pkg::byte_t     cmd_data,
    input  logic                out_ready,
    output logic                cmd_ready,
    output logic                out_valid,
    output uart_pkg::cmd_op_t   out_op,
    output uart_pkg::byte_t     out_data
);
    import uart_pkg::*;

    byte_t regs [REG_COUNT];
    logic  cmd_fire;

    // One outcome in flight, so a new command waits until it is gone
    assign cmd_ready = ~out_valid;
    assign cmd_fire  = cmd_valid & cmd_ready;

    // The registers are part of the visible state and start at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd_fire && cmd_op == CMD_WRITE) begin
            regs[cmd_addr] <= cmd_data;
        end
    end

    // Outcome register towards the result stage
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (cmd_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Read data is taken before any write in the same cycle could land
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            out_op <= cmd_op;
            if (cmd_op == CMD_READ) begin
                out_data <= regs[cmd_addr];
            end else begin
                out_data <= cmd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/resp_result.sv */
// Result stage that turns each outcome into one response byte for the transmitter
`timescale 1ns/1ns
`default_nettype none

module resp_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              out_valid,
    input  uart_pkg::cmd_op_t out_op,
    input  uart_pkg::byte_t   out_data,
    input  logic              tx_ready,
    output logic              out_ready,
    output logic              tx_valid,
    output uart_pkg::byte_t   tx_byte
);
    import uart_pkg::*;

    byte_t resp_byte;

    // Accept a new outcome only once the held byte has gone out
    assign out_ready = ~tx_valid;

    // Reads answer with the data, writes with an acknowledge
    always_comb begin
        case (out_op)
            CMD_READ:  resp_byte = out_data;
            CMD_WRITE: resp_byte = RESP_OK;
            default:   resp_byte = RESP_ERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_valid <= 1'b0;
        end else if (out_valid && out_ready) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    // The byte stays put until the transmitter has taken it
    always_ff @(posedge clk) begin
        if (out_valid && out_ready) begin
            tx_byte <= resp_byte;
        end
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
// Serial 8N1 transmitter that sends one byte per accepted request on the tx line
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int unsigned clk_hz = 1_000_000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            tx_valid,
    input  uart_pkg::byte_t tx_byte,
    input  logic [31:0]     uart_speed,
    output logic            tx_ready,
    output logic            tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    tx_state_t  state;
    baud_div_t  baud_div;
    baud_div_t  tick_count;
    logic       bit_done;
    logic [2:0] bit_index;
    byte_t      shift;

    assign baud_div = baud_div_t'(clk_hz / uart_speed);

    // Ready only between frames
    assign tx_ready = (state == IDLE);

    // High on the last clock of the current bit period
    assign bit_done = (tick_count == baud_div);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            tx         <= 1'b1;
            tick_count <= baud_div_t'(1);
            bit_index  <= 3'd0;
        end else begin
            if (state == IDLE || bit_done) begin
                tick_count <= baud_div_t'(1);
            end else begin
                tick_count <= tick_count + baud_div_t'(1);
            end
            case (state)
                IDLE: begin
                    // Start bit goes out on the cycle after acceptance
                    if (tx_valid) begin
                        tx    <= 1'b0;
                        state <= START;
                    end
                end
                START: begin
                    if (bit_done) begin
                        tx        <= shift[0];
                        bit_index <= 3'd0;
                        state     <= DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        if (bit_index == 3'd7) begin
                            tx    <= 1'b1;
                            state <= STOP;
                        end else begin
                            tx        <= shift[1];
                            bit_index <= bit_index + 3'd1;
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data bits leave LSB first, so the register shifts right
    always_ff @(posedge clk) begin
        if (state == IDLE && tx_valid) begin
            shift <= tx_byte;
        end else if (state == DATA && bit_done) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

`default_nettype wire

/* source/uart_cmd_top.sv */
// Top level of the UART register port, chaining receiver, decoder, registers and transmitter
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_top #(
    parameter int unsigned clk_hz = 1_000_000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        rx,
    input  logic [31:0] uart_speed,
    output logic        tx
);
    import uart_pkg::*;

    // Receiver to decoder, a pulse with no back pressure
    logic      rx_valid;
    byte_t     rx_byte;

    // Decoder to register file
    logic      cmd_valid;
    logic      cmd_ready;
    cmd_op_t   cmd_op;
    reg_addr_t cmd_addr;
    byte_t     cmd_data;

    // Register file to result stage
    logic      out_valid;
    logic      out_ready;
    cmd_op_t   out_op;
    byte_t     out_data;

    // Result stage to transmitter
    logic      tx_valid;
    logic      tx_ready;
    byte_t     tx_byte;

    uart_rx #(
        .clk_hz(clk_hz)
    ) u_rx (
        .clk(clk), .reset(reset), .rx(rx), .uart_speed(uart_speed),
        .rx_valid(rx_valid), .rx_byte(rx_byte)
    );

    cmd_decode u_decode (
        .clk(clk), .reset(reset), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .cmd_ready(cmd_ready), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_data(cmd_data)
    );

    reg_execute u_execute (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_data(cmd_data), .out_ready(out_ready),
        .cmd_ready(cmd_ready), .out_valid(out_valid), .out_op(out_op),
        .out_data(out_data)
    );

    resp_result u_result (
        .clk(clk), .reset(reset), .out_valid(out_valid), .out_op(out_op),
        .out_data(out_data), .tx_ready(tx_ready), .out_ready(out_ready),
        .tx_valid(tx_valid), .tx_byte(tx_byte)
    );

    uart_tx #(
        .clk_hz(clk_hz)
    ) u_tx (
        .clk(clk), .reset(reset), .tx_valid(tx_valid), .tx_byte(tx_byte),
        .uart_speed(uart_speed), .tx_ready(tx_ready), .tx(tx)
    );

endmodule

`default_nettype wire

/* tests/uart_cmd_tb.sv */
// Testbench for the UART register port that sends command frames on rx and checks each answer on tx
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_tb;
    import uart_pkg::*;

    localparam int unsigned clk_hz = 1_000_000;
    // Clocks allowed from the start of a frame to the start bit of its answer
    localparam int unsigned resp_timeout = 4000;
    localparam int random_pairs = 20;

    // One exchange with its line speed, frame bytes and expected answer
    typedef struct packed {
        logic [31:0] speed;
        logic [1:0]  len;
        byte_t       b0;
        byte_t       b1;
        byte_t       b2;
        byte_t       resp;
    } row_t;

    logic        clk;
    logic        reset;
    logic        rx;
    logic [31:0] uart_speed;
    logic        tx;

    row_t        table_q[$];
    byte_t       shadow [REG_COUNT];
    logic [31:0] lfsr;

    uart_cmd_top #(
        .clk_hz(clk_hz)
    ) DUT (
        .clk(clk), .reset(reset), .rx(rx), .uart_speed(uart_speed), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken with the newest bit in the LSB
    task automatic draw_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("ERR time=%0t %s got=%02h expected=%02h", $time, name, got, want);
            $display("TB FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("No %s seen within %0d clocks", what, resp_timeout);
        $display("TB FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic add_row(input logic [31:0] speed, input logic [1:0] len, input byte_t b0,
                           input byte_t b1, input byte_t b2, input byte_t resp);
        row_t r;
        r.speed = speed;
        r.len = len;
        r.b0 = b0;
        r.b1 = b1;
        r.b2 = b2;
        r.resp = resp;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        // Every register reads zero after reset while the speed alternates
        for (int i = 0; i < REG_COUNT; i++) begin
            add_row((i % 2 == 0) ? 32'd100_000 : 32'd50_000, 2'd2, OP_READ, byte_t'(i),
                    8'h00, 8'h00);
        end
        // Write then read back at both speeds
        add_row(32'd100_000, 2'd3, OP_WRITE, 8'h03, 8'hA5, RESP_OK);
        add_row(32'd100_000, 2'd2, OP_READ, 8'h03, 8'h00, 8'hA5);
        add_row(32'd50_000, 2'd3, OP_WRITE, 8'h07, 8'h3C, RESP_OK);
        add_row(32'd50_000, 2'd2, OP_READ, 8'h07, 8'h00, 8'h3C);
        // Unknown opcodes are single byte frames and the next command must still parse
        add_row(32'd100_000, 2'd1, 8'h11, 8'h00, 8'h00, RESP_ERR);
        add_row(32'd100_000, 2'd2, OP_READ, 8'h03, 8'h00, 8'hA5);
        add_row(32'd50_000, 2'd1, 8'hFF, 8'h00, 8'h00, RESP_ERR);
        add_row(32'd50_000, 2'd3, OP_WRITE, 8'h00, 8'h5A, RESP_OK);
        // Addresses of 16 and up are refused and leave the low four bit alias alone
        add_row(32'd100_000, 2'd2, OP_READ, 8'h10, 8'h00, RESP_ERR);
        add_row(32'd100_000, 2'd3, OP_WRITE, 8'h13, 8'hEE, RESP_ERR);
        add_row(32'd100_000, 2'd2, OP_READ, 8'h03, 8'h00, 8'hA5);
        add_row(32'd50_000, 2'd3, OP_WRITE, 8'h17, 8'h11, RESP_ERR);
        add_row(32'd50_000, 2'd2, OP_READ, 8'h07, 8'h00, 8'h3C);
        add_row(32'd50_000, 2'd2, OP_READ, 8'h00, 8'h00, 8'h5A);
        add_row(32'd100_000, 2'd3, OP_WRITE, 8'h0F, 8'h81, RESP_OK);
        add_row(32'd100_000, 2'd2, OP_READ, 8'h0F, 8'h00, 8'h81);
    endtask

    // Start bit, eight bits LSB first and a stop bit, each held for one bit period
    task automatic send_byte(input byte_t b, input int unsigned bit_clks);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input row_t r, input int unsigned bit_clks);
        send_byte(r.b0, bit_clks);
        if (r.len >= 2'd2) begin
            send_byte(r.b1, bit_clks);
        end
        if (r.len == 2'd3) begin
            send_byte(r.b2, bit_clks);
        end
    endtask

    // The line is read on the falling clock edge half a cycle away from any change
    task automatic receive_byte(input int unsigned bit_clks, output byte_t b);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            if (waited == resp_timeout) begin
                report_timeout("response start bit on tx");
            end
            waited++;
            @(negedge clk);
        end
        // Move to the middle of the start bit and then step one period per bit
        repeat (bit_clks / 2) @(negedge clk);
        check_value("tx start bit", {7'd0, tx}, 8'h00);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            b[i] = tx;
        end
        repeat (bit_clks) @(negedge clk);
        check_value("tx stop bit", {7'd0, tx}, 8'h01);
    endtask

    task automatic apply_row(input row_t r, input string name);
        int unsigned bit_clks;
        byte_t got;
        // The speed only changes while both lines are idle
        if (uart_speed != r.speed) begin
            @(posedge clk);
            uart_speed <= r.speed;
            repeat (4) @(posedge clk);
        end
        bit_clks = clk_hz / r.speed;
        // The answer may start before the last stop bit has been sent
        fork
            send_frame(r, bit_clks);
            receive_byte(bit_clks, got);
        join
        check_value(name, got, r.resp);
        // Let the answer's stop bit run out before anything else happens
        repeat (2 * bit_clks) @(posedge clk);
        if (r.b0 == OP_WRITE && r.b1 < byte_t'(REG_COUNT)) begin
            shadow[r.b1[3:0]] = r.b2;
        end
    endtask

    initial begin
        logic [7:0] speed_bits;
        logic [7:0] addr_bits;
        logic [7:0] data_bits;
        row_t r;
        reset = 1'b1;
        rx = 1'b1;
        uart_speed = 32'd100_000;
        lfsr = 32'h0acc_696b;
        for (int i = 0; i < REG_COUNT; i++) begin
            shadow[i] = 8'h00;
        end
        build_table();

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("tx idle level", {7'd0, tx}, 8'h01);

        for (int i = 0; i < table_q.size(); i++) begin
            apply_row(table_q[i], $sformatf("tx byte, table row %0d", i));
        end

        // Random write and read back pairs where the shadow array predicts each read
        for (int n = 0; n < random_pairs; n++) begin
            draw_bits(1, speed_bits);
            draw_bits(4, addr_bits);
            draw_bits(8, data_bits);
            r.speed = speed_bits[0] ? 32'd100_000 : 32'd50_000;
            r.len = 2'd3;
            r.b0 = OP_WRITE;
            r.b1 = addr_bits;
            r.b2 = data_bits;
            r.resp = RESP_OK;
            apply_row(r, $sformatf("tx byte, random write %0d", n));
            r.len = 2'd2;
            r.b0 = OP_READ;
            r.b2 = 8'h00;
            r.resp = shadow[addr_bits[3:0]];
            apply_row(r, $sformatf("tx byte, random read %0d", n));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/uart_pkg.sv
source/uart_rx.sv
source/cmd_decode.sv
source/reg_execute.sv
source/resp_result.sv
source/uart_tx.sv
source/uart_cmd_top.sv
tests/uart_cmd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the UART register port testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module uart_cmd_tb -f verilog.f \
    --Mdir obj_dir -o uart_cmd_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/uart_cmd_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
